//--- verilog/tx_cfg_pkg.sv
package tx_cfg_pkg;

  // payload datapath sizes
  localparam int data_width = 64;
  localparam int word_bytes = 8;
  localparam int len_width  = 32;
  localparam int pmtu_width = 13;

  typedef struct packed {
    logic [data_width-1:0] data;
    logic [word_bytes-1:0] keep;
    logic                  last;
  } payload_word_t;

  // one dma write transfer
  typedef struct packed {
    logic [len_width-1:0] length;
    logic [23:0]          rem_qpn;
    logic [23:0]          rem_psn;
    logic [31:0]          r_key;
    logic [31:0]          rem_ip;
    logic [63:0]          rem_addr;
  } dma_req_t;

endpackage

//--- verilog/roce_pkg.sv
package roce_pkg;

  // RC RDMA write opcodes
  localparam logic [7:0] op_write_first  = 8'h06;
  localparam logic [7:0] op_write_middle = 8'h07;
  localparam logic [7:0] op_write_last   = 8'h08;
  localparam logic [7:0] op_write_only   = 8'h0A;

  // header sizes in bytes, sized to match the udp length field
  localparam logic [15:0] bth_bytes     = 16'd12;
  localparam logic [15:0] reth_bytes    = 16'd16;
  localparam logic [15:0] udp_hdr_bytes = 16'd8;

  // fixed addressing and partition values
  localparam logic [15:0] roce_udp_port = 16'h12B7;
  localparam logic [15:0] loc_udp_port  = 16'h2123;
  localparam logic [31:0] loc_ip_addr   = {8'd22, 8'd1, 8'd212, 8'd10};
  localparam logic [15:0] p_key_default = 16'hFFFF;

  // base transport header
  typedef struct packed {
    logic [7:0]  op_code;
    logic [15:0] p_key;
    logic [23:0] psn;
    logic [23:0] dest_qp;
    logic        ack_req;
  } bth_t;

  // rdma extended transport header
  typedef struct packed {
    logic [63:0] v_addr;
    logic [31:0] r_key;
    logic [31:0] length;
  } reth_t;

  typedef struct packed {
    logic [31:0] src_ip;
    logic [31:0] dest_ip;
    logic [15:0] src_port;
    logic [15:0] dest_port;
    logic [15:0] udp_length;
  } ip_udp_t;

  // one packet as seen by the header generator
  typedef struct packed {
    logic [7:0]  op_code;
    logic [23:0] psn;
    logic [15:0] payload_len;
  } pkt_desc_t;

endpackage

//--- verilog/roce_tx_seg_ctrl.sv
`timescale 1ns/10ps

module roce_tx_seg_ctrl (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [tx_cfg_pkg::pmtu_width-1:0]   pmtu,
  input  tx_cfg_pkg::dma_req_t                s_req,
  input  tx_cfg_pkg::payload_word_t           s_data,
  input  logic                                s_valid,
  output logic                                s_ready,
  input  logic                                hdr_busy,
  input  logic                                ready_early,
  output tx_cfg_pkg::payload_word_t           word,
  output logic                                word_valid,
  output logic                                pkt_start,
  output roce_pkg::pkt_desc_t                 pkt_desc,
  output tx_cfg_pkg::dma_req_t                req
);

  typedef enum logic [2:0] {st_idle, st_first, st_middle, st_last, st_only} state_t;

  state_t state, state_next;
  tx_cfg_pkg::dma_req_t req_reg;

  logic [tx_cfg_pkg::len_width-1:0] rem_len, rem_len_next, rem_src, rem_after;
  logic [tx_cfg_pkg::len_width-1:0] pkt_cnt, pkt_cnt_next;
  logic [tx_cfg_pkg::len_width-1:0] pkt_len, pkt_len_next, cur_len, pmtu_len;
  logic [23:0] psn, psn_next, start_psn;
  logic [7:0]  start_op;
  logic        accept, first_beat, last_beat, s_ready_next;

  assign accept     = s_valid && s_ready;
  assign first_beat = (pkt_cnt == '0);
  assign pmtu_len   = {{(tx_cfg_pkg::len_width - tx_cfg_pkg::pmtu_width){1'b0}}, pmtu};

  // bytes still to come, taken from the request while idle
  assign rem_src   = (state == st_idle) ? s_req.length : rem_len;
  assign rem_after = rem_src - tx_cfg_pkg::word_bytes;

  // packet length is fixed on its first beat
  assign cur_len   = !first_beat ? pkt_len :
                     (rem_src <= pmtu_len) ? rem_src : pmtu_len;
  assign last_beat = (pkt_cnt + tx_cfg_pkg::word_bytes >= cur_len);

  always_comb begin
    if (state == st_idle) begin
      start_op  = (s_req.length <= pmtu_len) ? roce_pkg::op_write_only :
                                               roce_pkg::op_write_first;
      start_psn = s_req.rem_psn;
    end else begin
      start_op  = (state == st_last) ? roce_pkg::op_write_last :
                                       roce_pkg::op_write_middle;
      start_psn = psn + 24'd1;
    end
  end

  assign pkt_desc = '{op_code: start_op, psn: start_psn, payload_len: cur_len[15:0]};

  // header generator samples the request in the same cycle it is latched here
  assign req = (state == st_idle) ? s_req : req_reg;

  always_comb begin
    word       = s_data;
    word.last  = last_beat;
    word_valid = accept;
  end

  always_comb begin
    state_next   = state;
    rem_len_next = rem_len;
    pkt_cnt_next = pkt_cnt;
    pkt_len_next = pkt_len;
    psn_next     = psn;
    pkt_start    = 1'b0;
    if (accept) begin
      rem_len_next = rem_after;
      pkt_cnt_next = pkt_cnt + tx_cfg_pkg::word_bytes;
      if (first_beat) begin
        pkt_start    = 1'b1;
        pkt_len_next = cur_len;
        psn_next     = start_psn;
        if (state == st_idle) begin
          state_next = (start_op == roce_pkg::op_write_only) ? st_only : st_first;
        end
      end
      if (last_beat) begin
        pkt_cnt_next = '0;
        if (rem_after == '0) begin
          state_next = st_idle;
        end else if (rem_after <= pmtu_len) begin
          state_next = st_last;
        end else begin
          state_next = st_middle;
        end
      end
    end
    // a new packet may only start once the previous headers are gone
    s_ready_next = ready_early && !((pkt_cnt_next == '0) && (hdr_busy || pkt_start));
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_idle;
      pkt_cnt <= '0;
      s_ready <= 1'b0;
    end else begin
      state   <= state_next;
      pkt_cnt <= pkt_cnt_next;
      s_ready <= s_ready_next;
    end
    rem_len <= rem_len_next;
    pkt_len <= pkt_len_next;
    psn     <= psn_next;
    if (accept && state == st_idle) begin
      req_reg <= s_req;
    end
  end

endmodule

//--- verilog/roce_tx_hdr_gen.sv
`timescale 1ns/10ps

module roce_tx_hdr_gen (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 pkt_start,
  input  roce_pkg::pkt_desc_t  pkt_desc,
  input  tx_cfg_pkg::dma_req_t req,
  output logic                 hdr_busy,
  output roce_pkg::bth_t       m_bth,
  output roce_pkg::ip_udp_t    m_ip_udp,
  output logic                 m_bth_valid,
  input  logic                 m_bth_ready,
  output roce_pkg::reth_t      m_reth,
  output logic                 m_reth_valid,
  input  logic                 m_reth_ready
);

  logic        has_reth;
  logic [15:0] udp_length;

  // only the first packet of a transfer carries the reth
  assign has_reth = (pkt_desc.op_code == roce_pkg::op_write_first) ||
                    (pkt_desc.op_code == roce_pkg::op_write_only);

  // payload + bth + optional reth + udp header
  assign udp_length = pkt_desc.payload_len + roce_pkg::bth_bytes +
                      (has_reth ? roce_pkg::reth_bytes : 16'd0) + roce_pkg::udp_hdr_bytes;

  assign hdr_busy = m_bth_valid || m_reth_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      m_bth_valid  <= 1'b0;
      m_reth_valid <= 1'b0;
    end else if (pkt_start) begin
      m_bth_valid  <= 1'b1;
      m_reth_valid <= has_reth;
    end else begin
      m_bth_valid  <= m_bth_valid && !m_bth_ready;
      m_reth_valid <= m_reth_valid && !m_reth_ready;
    end
  end

  always_ff @(posedge clk) begin
    if (pkt_start) begin
      m_bth.op_code <= pkt_desc.op_code;
      m_bth.p_key   <= roce_pkg::p_key_default;
      m_bth.psn     <= pkt_desc.psn;
      m_bth.dest_qp <= req.rem_qpn;
      m_bth.ack_req <= 1'b1;

      m_ip_udp.src_ip     <= roce_pkg::loc_ip_addr;
      m_ip_udp.dest_ip    <= req.rem_ip;
      m_ip_udp.src_port   <= roce_pkg::loc_udp_port;
      m_ip_udp.dest_port  <= roce_pkg::roce_udp_port;
      m_ip_udp.udp_length <= udp_length;
    end
    // reth keeps its value across middle and last packets
    if (pkt_start && has_reth) begin
      m_reth.v_addr <= req.rem_addr;
      m_reth.r_key  <= req.r_key;
      m_reth.length <= req.length;
    end
  end

endmodule

//--- verilog/payload_skid_buf.sv
`timescale 1ns/10ps

module payload_skid_buf (
  input  logic                      clk,
  input  logic                      rst,
  input  tx_cfg_pkg::payload_word_t in_word,
  input  logic                      in_valid,
  output logic                      ready_early,
  output tx_cfg_pkg::payload_word_t out_word,
  output logic                      out_valid,
  input  logic                      out_ready
);

  tx_cfg_pkg::payload_word_t temp_word;
  logic temp_valid, ready_reg;
  logic out_valid_next, temp_valid_next;
  logic in_to_out, in_to_temp, temp_to_out;

  // room for one more beat next cycle
  assign ready_early = out_ready || (!temp_valid && !out_valid);

  always_comb begin
    out_valid_next  = out_valid;
    temp_valid_next = temp_valid;
    in_to_out       = 1'b0;
    in_to_temp      = 1'b0;
    temp_to_out     = 1'b0;
    if (ready_reg) begin
      if (out_ready || !out_valid) begin
        out_valid_next = in_valid;
        in_to_out      = 1'b1;
      end else begin
        // output stalled, park the beat in temp
        temp_valid_next = in_valid;
        in_to_temp      = 1'b1;
      end
    end else if (out_ready) begin
      out_valid_next  = temp_valid;
      temp_valid_next = 1'b0;
      temp_to_out     = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid  <= 1'b0;
      temp_valid <= 1'b0;
      ready_reg  <= 1'b0;
    end else begin
      out_valid  <= out_valid_next;
      temp_valid <= temp_valid_next;
      ready_reg  <= ready_early;
    end
    if (in_to_out) begin
      out_word <= in_word;
    end else if (temp_to_out) begin
      out_word <= temp_word;
    end
    if (in_to_temp) begin
      temp_word <= in_word;
    end
  end

endmodule

//--- verilog/roce_tx_top.sv
`timescale 1ns/10ps

module roce_tx_top (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [tx_cfg_pkg::pmtu_width-1:0] pmtu,
  input  tx_cfg_pkg::dma_req_t              s_req,
  input  tx_cfg_pkg::payload_word_t         s_data,
  input  logic                              s_valid,
  output logic                              s_ready,
  output tx_cfg_pkg::payload_word_t         m_data,
  output logic                              m_valid,
  input  logic                              m_ready,
  output roce_pkg::bth_t                    m_bth,
  output roce_pkg::ip_udp_t                 m_ip_udp,
  output logic                              m_bth_valid,
  input  logic                              m_bth_ready,
  output roce_pkg::reth_t                   m_reth,
  output logic                              m_reth_valid,
  input  logic                              m_reth_ready
);

  tx_cfg_pkg::payload_word_t word;
  tx_cfg_pkg::dma_req_t      req;
  roce_pkg::pkt_desc_t       pkt_desc;
  logic word_valid, ready_early, pkt_start, hdr_busy;

  roce_tx_seg_ctrl roce_tx_seg_ctrl_inst (
    .clk(clk), .rst(rst), .pmtu(pmtu), .s_req(s_req),
    .s_data(s_data), .s_valid(s_valid), .s_ready(s_ready),
    .hdr_busy(hdr_busy), .ready_early(ready_early),
    .word(word), .word_valid(word_valid),
    .pkt_start(pkt_start), .pkt_desc(pkt_desc), .req(req)
  );

  roce_tx_hdr_gen roce_tx_hdr_gen_inst (
    .clk(clk), .rst(rst), .pkt_start(pkt_start), .pkt_desc(pkt_desc), .req(req),
    .hdr_busy(hdr_busy), .m_bth(m_bth), .m_ip_udp(m_ip_udp),
    .m_bth_valid(m_bth_valid), .m_bth_ready(m_bth_ready),
    .m_reth(m_reth), .m_reth_valid(m_reth_valid), .m_reth_ready(m_reth_ready)
  );

  payload_skid_buf payload_skid_buf_inst (
    .clk(clk), .rst(rst), .in_word(word), .in_valid(word_valid),
    .ready_early(ready_early), .out_word(m_data), .out_valid(m_valid),
    .out_ready(m_ready)
  );

endmodule

//--- sim/roce_tx_assert.sv
`timescale 1ns/10ps

module roce_tx_assert (
  input logic                      clk,
  input logic                      rst,
  input tx_cfg_pkg::payload_word_t m_data,
  input logic                      m_valid,
  input logic                      m_ready,
  input roce_pkg::bth_t            m_bth,
  input roce_pkg::ip_udp_t         m_ip_udp,
  input logic                      m_bth_valid,
  input logic                      m_bth_ready,
  input roce_pkg::reth_t           m_reth,
  input logic                      m_reth_valid,
  input logic                      m_reth_ready
);

  // a stalled beat or header stays put until taken
  payload_hold: assert property (@(posedge clk) disable iff (rst)
    m_valid && !m_ready |=> m_valid && $stable(m_data))
    else $error("payload word dropped or changed while stalled");

  bth_hold: assert property (@(posedge clk) disable iff (rst)
    m_bth_valid && !m_bth_ready |=> m_bth_valid && $stable(m_bth) && $stable(m_ip_udp))
    else $error("bth dropped or changed while stalled");

  reth_hold: assert property (@(posedge clk) disable iff (rst)
    m_reth_valid && !m_reth_ready |=> m_reth_valid && $stable(m_reth))
    else $error("reth dropped or changed while stalled");

  // all output valids idle in reset
  reset_idle: assert property (@(posedge clk)
    rst |=> !m_valid && !m_bth_valid && !m_reth_valid)
    else $error("output valid high during reset");

endmodule

bind roce_tx_top roce_tx_assert roce_tx_assert_inst (
  .clk(clk), .rst(rst), .m_data(m_data), .m_valid(m_valid), .m_ready(m_ready),
  .m_bth(m_bth), .m_ip_udp(m_ip_udp), .m_bth_valid(m_bth_valid), .m_bth_ready(m_bth_ready),
  .m_reth(m_reth), .m_reth_valid(m_reth_valid), .m_reth_ready(m_reth_ready)
);

//--- sim/roce_tx_tb.sv
`timescale 1ns/10ps

module roce_tx_tb;

  // input beats over all tests set the timeout
  localparam int total_beats    = 4 + 125 + 64 + 48 + 16;
  localparam int timeout_cycles = total_beats * 4 + 200;

  logic clk = 1'b0;
  logic rst;
  logic [tx_cfg_pkg::pmtu_width-1:0] pmtu;
  tx_cfg_pkg::dma_req_t      s_req;
  tx_cfg_pkg::payload_word_t s_data, m_data;
  logic s_valid, s_ready, m_valid, m_ready;
  roce_pkg::bth_t    m_bth;
  roce_pkg::ip_udp_t m_ip_udp;
  roce_pkg::reth_t   m_reth;
  logic m_bth_valid, m_bth_ready, m_reth_valid, m_reth_ready;

  integer seed = 32'h668e_9626;
  int     cycle_cnt = 0;
  int     xfer_cnt = 0;

  tx_cfg_pkg::payload_word_t exp_data[$];
  tx_cfg_pkg::payload_word_t got_data[$];
  roce_pkg::bth_t            got_bth[$];
  roce_pkg::ip_udp_t         got_ip_udp[$];
  roce_pkg::reth_t           got_reth[$];

  roce_tx_top roce_tx_top_inst (
    .clk(clk), .rst(rst), .pmtu(pmtu), .s_req(s_req),
    .s_data(s_data), .s_valid(s_valid), .s_ready(s_ready),
    .m_data(m_data), .m_valid(m_valid), .m_ready(m_ready),
    .m_bth(m_bth), .m_ip_udp(m_ip_udp), .m_bth_valid(m_bth_valid), .m_bth_ready(m_bth_ready),
    .m_reth(m_reth), .m_reth_valid(m_reth_valid), .m_reth_ready(m_reth_ready)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout after %0d cycles, the DUT stopped producing output", cycle_cnt);
      $display("Testbench failed");
      $fatal(1);
    end
  end

  // collector for every completed output handshake
  always @(posedge clk) begin
    if (!rst) begin
      if (m_valid && m_ready) begin
        got_data.push_back(m_data);
      end
      if (m_bth_valid && m_bth_ready) begin
        got_bth.push_back(m_bth);
        got_ip_udp.push_back(m_ip_udp);
      end
      if (m_reth_valid && m_reth_ready) begin
        got_reth.push_back(m_reth);
      end
    end
  end

  task automatic compare_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %0h, expected %0h", name, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  // feed one transfer and queue the words expected at the output
  task automatic send_transfer(input tx_cfg_pkg::dma_req_t req);
    tx_cfg_pkg::payload_word_t w;
    int nbeats;
    int idx;
    int offs;
    nbeats = int'(req.length) / tx_cfg_pkg::word_bytes;
    idx = 0;
    exp_data.delete();
    got_data.delete();
    got_bth.delete();
    got_ip_udp.delete();
    got_reth.delete();
    xfer_cnt++;
    s_req <= req;
    while (idx < nbeats) begin
      w.data = {16'(xfer_cnt), 16'(idx), 32'(idx) * 32'h9E37_79B9};
      w.keep = 8'hFF;
      s_data  <= w;
      s_valid <= 1'b1;
      @(posedge clk);
      while (!s_ready) begin
        @(posedge clk);
      end
      offs = (idx * tx_cfg_pkg::word_bytes) % int'(pmtu);
      // a packet may only start once the previous headers are taken
      if (offs == 0) begin
        compare_value("header valid at packet start", 128'(m_bth_valid || m_reth_valid), 128'(0));
      end
      w.last = (offs + tx_cfg_pkg::word_bytes == int'(pmtu)) || (idx == nbeats - 1);
      exp_data.push_back(w);
      idx++;
    end
    s_valid <= 1'b0;
  endtask

  // wait for all outputs and compare with packets built by segmenting the request
  task automatic check_transfer(input tx_cfg_pkg::dma_req_t req);
    roce_pkg::bth_t    eb;
    roce_pkg::ip_udp_t eu;
    roce_pkg::reth_t   er;
    logic [7:0]  op;
    logic [23:0] psn;
    int npkts;
    int rem;
    int plen;
    npkts = (int'(req.length) + int'(pmtu) - 1) / int'(pmtu);
    while (got_data.size() < exp_data.size() || got_bth.size() < npkts ||
           got_reth.size() < 1) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    compare_value("payload beat count", 128'(got_data.size()), 128'(exp_data.size()));
    compare_value("bth count", 128'(got_bth.size()), 128'(npkts));
    compare_value("reth count", 128'(got_reth.size()), 128'(1));
    foreach (exp_data[i]) begin
      compare_value("m_data", 128'(got_data[i]), 128'(exp_data[i]));
    end
    rem = int'(req.length);
    psn = req.rem_psn;
    for (int k = 0; k < npkts; k++) begin
      plen = (rem < int'(pmtu)) ? rem : int'(pmtu);
      if (npkts == 1) begin
        op = roce_pkg::op_write_only;
      end else if (k == 0) begin
        op = roce_pkg::op_write_first;
      end else if (k == npkts - 1) begin
        op = roce_pkg::op_write_last;
      end else begin
        op = roce_pkg::op_write_middle;
      end
      eb = '{op_code: op, p_key: 16'hFFFF, psn: psn, dest_qp: req.rem_qpn, ack_req: 1'b1};
      eu = '{src_ip: roce_pkg::loc_ip_addr, dest_ip: req.rem_ip,
             src_port: roce_pkg::loc_udp_port, dest_port: roce_pkg::roce_udp_port,
             udp_length: 16'(plen + 12 + ((k == 0) ? 16 : 0) + 8)};
      compare_value("m_bth", 128'(got_bth[k]), 128'(eb));
      compare_value("m_ip_udp", 128'(got_ip_udp[k]), 128'(eu));
      rem = rem - plen;
      psn = psn + 24'd1;
    end
    er = '{v_addr: req.rem_addr, r_key: req.r_key, length: req.length};
    compare_value("m_reth", 128'(got_reth[0]), 128'(er));
  endtask

  // random output back-pressure with ready about three cycles in four
  task automatic apply_stalls(input int cycles);
    logic [31:0] rnd;
    repeat (cycles) begin
      @(posedge clk);
      rnd = $random(seed);
      m_ready <= rnd[0] | rnd[1];
    end
    m_ready <= 1'b1;
  endtask

  task automatic single_packet();
    tx_cfg_pkg::dma_req_t req;
    req = '{length: 32'd32, rem_qpn: 24'h00_0123, rem_psn: 24'h00_0010,
            r_key: 32'h1234_5678, rem_ip: 32'h0A00_0002, rem_addr: 64'h0000_1000_0000_0040};
    @(posedge clk);
    compare_value("s_ready", 128'(s_ready), 128'(0));
    compare_value("m_valid", 128'(m_valid), 128'(0));
    compare_value("m_bth_valid", 128'(m_bth_valid), 128'(0));
    compare_value("m_reth_valid", 128'(m_reth_valid), 128'(0));
    @(posedge clk);
    compare_value("s_ready", 128'(s_ready), 128'(1));
    pmtu <= 13'd256;
    send_transfer(req);
    check_transfer(req);
    compare_value("m_bth.op_code", 128'(got_bth[0].op_code), 128'(8'h0A));
    compare_value("m_bth.psn", 128'(got_bth[0].psn), 128'(24'h00_0010));
    compare_value("m_ip_udp.udp_length", 128'(got_ip_udp[0].udp_length), 128'(68));
    compare_value("m_data.last", 128'(got_data[3].last), 128'(1));
  endtask

  task automatic multi_packet();
    tx_cfg_pkg::dma_req_t req;
    int         exp_udp[4] = '{292, 276, 276, 252};
    logic [7:0] exp_op[4]  = '{8'h06, 8'h07, 8'h07, 8'h08};
    req = '{length: 32'd1000, rem_qpn: 24'h45_6789, rem_psn: 24'h00_5000,
            r_key: 32'hCAFE_0001, rem_ip: 32'hC0A8_0107, rem_addr: 64'h0000_0002_0000_1000};
    pmtu <= 13'd256;
    send_transfer(req);
    check_transfer(req);
    for (int k = 0; k < 4; k++) begin
      compare_value("m_bth.op_code", 128'(got_bth[k].op_code), 128'(exp_op[k]));
      compare_value("m_bth.psn", 128'(got_bth[k].psn), 128'(24'h00_5000 + 24'(k)));
      compare_value("m_ip_udp.udp_length", 128'(got_ip_udp[k].udp_length), 128'(exp_udp[k]));
    end
  endtask

  task automatic exact_pmtu_multiple();
    tx_cfg_pkg::dma_req_t req;
    req = '{length: 32'd512, rem_qpn: 24'h00_0042, rem_psn: 24'h7F_FFFE,
            r_key: 32'h0BAD_F00D, rem_ip: 32'h0A01_0203, rem_addr: 64'h0000_0000_8000_0000};
    pmtu <= 13'd256;
    send_transfer(req);
    check_transfer(req);
    compare_value("m_bth.op_code", 128'(got_bth[0].op_code), 128'(8'h06));
    compare_value("m_bth.op_code", 128'(got_bth[1].op_code), 128'(8'h08));
    for (int i = 0; i < 64; i++) begin
      compare_value("m_data.last", 128'(got_data[i].last), 128'((i == 31) || (i == 63)));
    end
  endtask

  task automatic payload_backpressure();
    tx_cfg_pkg::dma_req_t req;
    req = '{length: 32'd384, rem_qpn: 24'h12_3456, rem_psn: 24'h00_0777,
            r_key: 32'h5555_AAAA, rem_ip: 32'h0A00_00FE, rem_addr: 64'h0000_0003_0000_0200};
    pmtu <= 13'd128;
    fork
      send_transfer(req);
      apply_stalls(150);
    join
    check_transfer(req);
  endtask

  // bth held for 20 cycles and reth for 12 while the first packet of two is sent
  task automatic header_backpressure();
    tx_cfg_pkg::dma_req_t req;
    req = '{length: 32'd128, rem_qpn: 24'h00_0F0F, rem_psn: 24'hFF_FFFF,
            r_key: 32'h0000_BEEF, rem_ip: 32'h0A00_0009, rem_addr: 64'h0000_0000_0001_0000};
    pmtu <= 13'd64;
    fork
      send_transfer(req);
      begin
        m_bth_ready  <= 1'b0;
        m_reth_ready <= 1'b0;
        repeat (12) @(posedge clk);
        m_reth_ready <= 1'b1;
        repeat (8) @(posedge clk);
        m_bth_ready  <= 1'b1;
      end
    join
    check_transfer(req);
    compare_value("m_bth.psn", 128'(got_bth[0].psn), 128'(24'hFF_FFFF));
    compare_value("m_bth.psn", 128'(got_bth[1].psn), 128'(24'h00_0000));
  endtask

  initial begin
    rst          <= 1'b1;
    pmtu         <= 13'd256;
    s_req        <= '0;
    s_data       <= '0;
    s_valid      <= 1'b0;
    m_ready      <= 1'b1;
    m_bth_ready  <= 1'b1;
    m_reth_ready <= 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    single_packet();
    multi_packet();
    exact_pmtu_multiple();
    payload_backpressure();
    header_backpressure();
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- vlog.f
verilog/tx_cfg_pkg.sv
verilog/roce_pkg.sv
verilog/roce_tx_seg_ctrl.sv
verilog/roce_tx_hdr_gen.sv
verilog/payload_skid_buf.sv
verilog/roce_tx_top.sv
sim/roce_tx_assert.sv
sim/roce_tx_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= roce_tx_tb
FLAGS     ?= --binary --assert -j 0
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
PASS_MSG  := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the status comes from the search for the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
